// File: project.f
src/issue_pkg.sv
src/int_regfile.sv
src/issue_hazard_check.sv
src/operand_select.sv
src/issue_output_reg.sv
src/issue_read_operands.sv
tb/tb_issue_read_operands.sv

// File: src/int_regfile.sv
// integer register file, two combinational read ports, commit write ports, x0 tied to zero
`timescale 1ns/10ps

module int_regfile #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  issue_pkg::reg_addr_t                         raddr_a_i,
    input  issue_pkg::reg_addr_t                         raddr_b_i,
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    output issue_pkg::xlen_t                             rdata_a_o,
    output issue_pkg::xlen_t                             rdata_b_o
);
    import issue_pkg::*;

    localparam int unsigned NR_REGS = 2 ** REG_ADDR_SIZE;

    xlen_t mem_q [NR_REGS];

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    // ports are walked in ascending order, so the highest index
    // hitting the same register is the one that lands
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 0; r < NR_REGS; r++) begin
                mem_q[r] <= '0;
            end
        end else begin
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                // x0 is never written, it keeps its reset value
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    mem_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    // no write-through, a same-cycle write shows up after the edge
    assign rdata_a_o = mem_q[raddr_a_i];
    assign rdata_b_o = mem_q[raddr_b_i];

endmodule

// File: src/issue_hazard_check.sv
// source clobber and forwarding check, unit busy select, WAW check and issue ack
`timescale 1ns/10ps

module issue_hazard_check #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  issue_pkg::issue_entry_t                        issue_instr_i,
    input  logic                                           issue_valid_i,
    input  issue_pkg::fu_t [2**issue_pkg::REG_ADDR_SIZE-1:0] rd_clobber_i,
    input  logic                                           rs1_valid_i,
    input  logic                                           rs2_valid_i,
    input  issue_pkg::fu_ready_t                           fu_ready_i,
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i,
    input  logic                                           mult_issued_i,
    output logic                                           forward_rs1_o,
    output logic                                           forward_rs2_o,
    output logic                                           issue_ack_o,
    output logic                                           issue_fire_o
);
    import issue_pkg::*;

    logic stall;
    logic fu_busy;
    logic rd_free;

    // ------------------------------------------------------------------------
    // source operands
    // ------------------------------------------------------------------------
    always_comb begin : operands_available
        stall         = 1'b0;
        forward_rs1_o = 1'b0;
        forward_rs2_o = 1'b0;
        // rs1 carries the zimm for CSR immediates, nothing to wait on then
        if (!issue_instr_i.use_zimm && (rd_clobber_i[issue_instr_i.rs1] != NONE)) begin
            // CSR results never come back through the scoreboard
            if (rs1_valid_i && (rd_clobber_i[issue_instr_i.rs1] != CSR)) begin
                forward_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rd_clobber_i[issue_instr_i.rs2] != NONE) begin
            if (rs2_valid_i && (rd_clobber_i[issue_instr_i.rs2] != CSR)) begin
                forward_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy flag of the unit this instruction needs
    always_comb begin : unit_busy
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~fu_ready_i.flu;
            LOAD, STORE:               fu_busy = ~fu_ready_i.lsu;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // write after write
    // ------------------------------------------------------------------------
    // rd is usable if nobody owns it, or its owner commits right now
    always_comb begin : waw_check
        rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_free = 1'b1;
            end
        end
    end

    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less ops just drain, no unit needed
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // a multiply in flight owns the fixed-latency writeback next cycle
        if (mult_issued_i && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    assign issue_fire_o = issue_ack_o & issue_valid_i & ~issue_instr_i.ex_valid;

endmodule

// File: src/issue_output_reg.sv
// issue to execute pipeline register and one-hot unit valid pulses with flush
`timescale 1ns/10ps

module issue_output_reg (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    issue_fire_i,
    input  issue_pkg::fu_t          fu_i,
    input  issue_pkg::fu_data_t     fu_data_next_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::unit_valid_t  unit_valid_o,
    output logic                    mult_issued_o
);
    import issue_pkg::*;

    unit_valid_t unit_valid_d;

    // ------------------------------------------------------------------------
    // payload
    // ------------------------------------------------------------------------
    // loaded every cycle, the unit valids tell execute when it counts
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o <= '{fu: NONE, op: ADD, default: '0};
        end else begin
            fu_data_o <= fu_data_next_i;
        end
    end

    // ------------------------------------------------------------------------
    // unit valids
    // ------------------------------------------------------------------------
    // pulse decode, one cycle wide since it clears by default
    always_comb begin : valid_decode
        unit_valid_d = '0;
        if (issue_fire_i) begin
            case (fu_i)
                ALU:         unit_valid_d.alu    = 1'b1;
                CTRL_FLOW:   unit_valid_d.branch = 1'b1;
                MULT:        unit_valid_d.mult   = 1'b1;
                LOAD, STORE: unit_valid_d.lsu    = 1'b1;
                CSR:         unit_valid_d.csr    = 1'b1;
                default:     unit_valid_d        = '0;
            endcase
        end
        // a flushed instruction must not start its unit
        if (flush_i) begin
            unit_valid_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            unit_valid_o <= '0;
        end else begin
            unit_valid_o <= unit_valid_d;
        end
    end

    // fed back to hold off non-mult issue for one cycle
    assign mult_issued_o = unit_valid_o.mult;

endmodule

// File: src/issue_pkg.sv
// shared widths, functional-unit and operator enums, issue and commit structs
package issue_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned REG_ADDR_SIZE = 5;
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [REG_ADDR_SIZE-1:0] reg_addr_t;

    // ------------------------------------------------------------------------
    // functional units and operators
    // ------------------------------------------------------------------------
    // NONE marks a free register in the clobber table
    typedef enum logic [2:0] {
        NONE, ALU, CTRL_FLOW, CSR, MULT, LOAD, STORE
    } fu_t;

    // ADD sits at zero so a cleared register decodes as a plain add
    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        MUL, MULH, DIV, REM,
        LW, LH, LB, SW, SH, SB,
        BEQ, BNE, BLT, BGE, JAL, JALR,
        CSRRW, CSRRS, CSRRC
    } fu_op_t;

    // ------------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------------
    // one scoreboard entry offered for issue
    typedef struct packed {
        xlen_t                    pc;
        logic [TRANS_ID_BITS-1:0] trans_id;
        fu_t                      fu;
        fu_op_t                   op;
        reg_addr_t                rs1;
        reg_addr_t                rs2;
        reg_addr_t                rd;
        xlen_t                    result;        // immediate from decode
        logic                     use_imm;
        logic                     use_zimm;
        logic                     use_pc;
        logic                     ex_valid;      // exception already raised
        logic                     is_compressed;
    } issue_entry_t;

    // a single write from the commit stage
    typedef struct packed {
        reg_addr_t waddr;
        xlen_t     wdata;
        logic      we;
    } commit_port_t;

    // flu covers ALU, CTRL_FLOW, CSR and MULT
    typedef struct packed {
        logic flu;
        logic lsu;
    } fu_ready_t;

    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } unit_valid_t;

    // payload handed to execute
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   op;
        xlen_t                    operand_a;
        xlen_t                    operand_b;
        xlen_t                    imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
        xlen_t                    pc;
        logic                     is_compressed;
    } fu_data_t;

endpackage

// File: src/issue_read_operands.sv
// issue and operand read top, hazard check, register file, operand select, output register
`timescale 1ns/10ps

module issue_read_operands #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           flush_i,
    // scoreboard issue
    input  issue_pkg::issue_entry_t                        issue_instr_i,
    input  logic                                           issue_valid_i,
    output logic                                           issue_ack_o,
    // scoreboard lookup
    output issue_pkg::reg_addr_t                           rs1_o,
    input  issue_pkg::xlen_t                               rs1_i,
    input  logic                                           rs1_valid_i,
    output issue_pkg::reg_addr_t                           rs2_o,
    input  issue_pkg::xlen_t                               rs2_i,
    input  logic                                           rs2_valid_i,
    input  issue_pkg::fu_t [2**issue_pkg::REG_ADDR_SIZE-1:0] rd_clobber_i,
    // execute side
    input  issue_pkg::fu_ready_t                           fu_ready_i,
    output issue_pkg::fu_data_t                            fu_data_o,
    output issue_pkg::unit_valid_t                         unit_valid_o,
    // commit writes
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i
);
    import issue_pkg::*;

    logic     forward_rs1;
    logic     forward_rs2;
    logic     issue_fire;
    logic     mult_issued;
    xlen_t    rf_rdata_a;
    xlen_t    rf_rdata_b;
    fu_data_t fu_data_next;

    // scoreboard lookup straight from the instruction
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // ------------------------------------------------------------------------
    // decode: hazards and ack
    // ------------------------------------------------------------------------
    issue_hazard_check #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_issue_hazard_check (
        .issue_instr_i   ( issue_instr_i ),
        .issue_valid_i   ( issue_valid_i ),
        .rd_clobber_i    ( rd_clobber_i  ),
        .rs1_valid_i     ( rs1_valid_i   ),
        .rs2_valid_i     ( rs2_valid_i   ),
        .fu_ready_i      ( fu_ready_i    ),
        .commit_i        ( commit_i      ),
        .mult_issued_i   ( mult_issued   ),
        .forward_rs1_o   ( forward_rs1   ),
        .forward_rs2_o   ( forward_rs2   ),
        .issue_ack_o     ( issue_ack_o   ),
        .issue_fire_o    ( issue_fire    )
    );

    // ------------------------------------------------------------------------
    // execute: register read and operand mux
    // ------------------------------------------------------------------------
    int_regfile #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_int_regfile (
        .clk_i     ( clk_i             ),
        .rst_ni    ( rst_ni            ),
        .raddr_a_i ( issue_instr_i.rs1 ),
        .raddr_b_i ( issue_instr_i.rs2 ),
        .commit_i  ( commit_i          ),
        .rdata_a_o ( rf_rdata_a        ),
        .rdata_b_o ( rf_rdata_b        )
    );

    operand_select i_operand_select (
        .issue_instr_i  ( issue_instr_i ),
        .rf_a_i         ( rf_rdata_a    ),
        .rf_b_i         ( rf_rdata_b    ),
        .rs1_i          ( rs1_i         ),
        .rs2_i          ( rs2_i         ),
        .forward_rs1_i  ( forward_rs1   ),
        .forward_rs2_i  ( forward_rs2   ),
        .fu_data_next_o ( fu_data_next  )
    );

    // ------------------------------------------------------------------------
    // result: issue register
    // ------------------------------------------------------------------------
    issue_output_reg i_issue_output_reg (
        .clk_i          ( clk_i            ),
        .rst_ni         ( rst_ni           ),
        .flush_i        ( flush_i          ),
        .issue_fire_i   ( issue_fire       ),
        .fu_i           ( issue_instr_i.fu ),
        .fu_data_next_i ( fu_data_next     ),
        .fu_data_o      ( fu_data_o        ),
        .unit_valid_o   ( unit_valid_o     ),
        .mult_issued_o  ( mult_issued      )
    );

endmodule

// File: src/operand_select.sv
// operand a, operand b and immediate mux from register file, forwarding and instruction fields
`timescale 1ns/10ps

module operand_select (
    input  issue_pkg::issue_entry_t issue_instr_i,
    input  issue_pkg::xlen_t        rf_a_i,
    input  issue_pkg::xlen_t        rf_b_i,
    input  issue_pkg::xlen_t        rs1_i,
    input  issue_pkg::xlen_t        rs2_i,
    input  logic                    forward_rs1_i,
    input  logic                    forward_rs2_i,
    output issue_pkg::fu_data_t     fu_data_next_o
);
    import issue_pkg::*;

    xlen_t operand_a;
    xlen_t operand_b;

    // ------------------------------------------------------------------------
    // operand a
    // ------------------------------------------------------------------------
    // later assignments take priority: zimm over pc over register
    always_comb begin : sel_operand_a
        operand_a = forward_rs1_i ? rs1_i : rf_a_i;
        if (issue_instr_i.use_pc) begin
            operand_a = issue_instr_i.pc;
        end
        if (issue_instr_i.use_zimm) begin
            operand_a = {{(XLEN-REG_ADDR_SIZE){1'b0}}, issue_instr_i.rs1};
        end
    end

    // ------------------------------------------------------------------------
    // operand b
    // ------------------------------------------------------------------------
    // stores and branches need rs2 itself, their imm rides in the imm field
    always_comb begin : sel_operand_b
        operand_b = forward_rs2_i ? rs2_i : rf_b_i;
        if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE)
                && (issue_instr_i.fu != CTRL_FLOW)) begin
            operand_b = issue_instr_i.result;
        end
    end

    // rest of the payload is a straight copy
    assign fu_data_next_o = '{
        fu:            issue_instr_i.fu,
        op:            issue_instr_i.op,
        operand_a:     operand_a,
        operand_b:     operand_b,
        imm:           issue_instr_i.result,
        trans_id:      issue_instr_i.trans_id,
        pc:            issue_instr_i.pc,
        is_compressed: issue_instr_i.is_compressed
    };

endmodule

// File: tb/tb_issue_read_operands.sv
// issue stage testbench with clock, reset, lfsr, shadow registers, checks and timeout
`timescale 1ns/10ps

module tb_issue_read_operands;
    import issue_pkg::*;

    localparam int unsigned MAX_CYCLES = 400;
    localparam unit_valid_t V_NONE = 5'b00000;
    localparam unit_valid_t V_ALU  = 5'b10000;
    localparam unit_valid_t V_BR   = 5'b01000;
    localparam unit_valid_t V_LSU  = 5'b00100;
    localparam unit_valid_t V_MUL  = 5'b00010;
    localparam unit_valid_t V_CSR  = 5'b00001;

    logic clk_i;
    logic rst_ni;
    logic flush;
    issue_entry_t issue_instr;
    logic issue_valid;
    logic issue_ack;
    reg_addr_t rs1_lookup;
    reg_addr_t rs2_lookup;
    xlen_t rs1_fwd;
    xlen_t rs2_fwd;
    logic rs1_valid;
    logic rs2_valid;
    fu_t [31:0] rd_clobber;
    fu_ready_t fu_ready;
    fu_data_t fu_data;
    unit_valid_t unit_valid;
    commit_port_t [1:0] commit;
    xlen_t shadow [32];
    logic [15:0] lfsr_q = 16'd25;
    int unsigned cycles = 0;
    int mismatch_count = 0;
    int ack_mismatch_count = 0;

    issue_read_operands #(
        .NR_COMMIT_PORTS ( 2 )
    ) uut (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .flush_i       ( flush       ),
        .issue_instr_i ( issue_instr ),
        .issue_valid_i ( issue_valid ),
        .issue_ack_o   ( issue_ack   ),
        .rs1_o         ( rs1_lookup  ),
        .rs1_i         ( rs1_fwd     ),
        .rs1_valid_i   ( rs1_valid   ),
        .rs2_o         ( rs2_lookup  ),
        .rs2_i         ( rs2_fwd     ),
        .rs2_valid_i   ( rs2_valid   ),
        .rd_clobber_i  ( rd_clobber  ),
        .fu_ready_i    ( fu_ready    ),
        .fu_data_o     ( fu_data     ),
        .unit_valid_o  ( unit_valid  ),
        .commit_i      ( commit      )
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // run limit from the test length plus margin
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic issue_entry_t make_instr(input fu_t fu, input fu_op_t op,
            input reg_addr_t rs1, input reg_addr_t rs2, input reg_addr_t rd);
        issue_entry_t e;
        e = '0;
        e.pc = 32'h8000_0400;
        e.trans_id = 3'd3;
        e.fu = fu;
        e.op = op;
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.rd = rd;
        e.result = 32'h0000_07f3;
        e.is_compressed = 1'b1;
        return e;
    endfunction

    // write both ports in one cycle and mirror them into the shadow in port order
    task automatic commit_pair(input reg_addr_t a0, input xlen_t d0,
            input reg_addr_t a1, input xlen_t d1);
        commit[0] = '{waddr: a0, wdata: d0, we: 1'b1};
        commit[1] = '{waddr: a1, wdata: d1, we: 1'b1};
        @(negedge clk_i);
        commit = '0;
        if (a0 != '0) shadow[a0] = d0;
        if (a1 != '0) shadow[a1] = d1;
    endtask

    // drive at a falling edge and sample the ack once it settles
    // registered outputs are read back at the next falling edge
    task automatic issue_check(input issue_entry_t instr, input logic exp_ack,
            input unit_valid_t exp_valid, input logic chk_ops,
            input xlen_t exp_a, input xlen_t exp_b);
        issue_instr = instr;
        issue_valid = 1'b1;
        #1;
        assert (issue_ack == exp_ack) else begin
            ack_mismatch_count++;
            $display("Mismatch at %0t: issue_ack_o %0b, expected %0b",
                     $time, issue_ack, exp_ack);
        end
        assert ((rs1_lookup == instr.rs1) && (rs2_lookup == instr.rs2)) else begin
            mismatch_count++;
            $display("Mismatch at %0t: rs1_o %0d rs2_o %0d, expected %0d %0d",
                     $time, rs1_lookup, rs2_lookup, instr.rs1, instr.rs2);
        end
        @(negedge clk_i);
        assert (unit_valid == exp_valid) else begin
            mismatch_count++;
            $display("Mismatch at %0t: unit_valid_o %b, expected %b",
                     $time, unit_valid, exp_valid);
        end
        if (chk_ops) begin
            assert (fu_data.operand_a == exp_a) else begin
                mismatch_count++;
                $display("Mismatch at %0t: operand_a %h, expected %h",
                         $time, fu_data.operand_a, exp_a);
            end
            assert (fu_data.operand_b == exp_b) else begin
                mismatch_count++;
                $display("Mismatch at %0t: operand_b %h, expected %h",
                         $time, fu_data.operand_b, exp_b);
            end
            assert ((fu_data.imm == instr.result) && (fu_data.fu == instr.fu)
                    && (fu_data.op == instr.op) && (fu_data.pc == instr.pc)
                    && (fu_data.trans_id == instr.trans_id)
                    && (fu_data.is_compressed == instr.is_compressed)) else begin
                mismatch_count++;
                $display("Mismatch at %0t: payload fields not copied from the instruction",
                         $time);
            end
        end
        issue_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] d;
        reg_addr_t ra;
        reg_addr_t rb;
        issue_entry_t ins;
        rst_ni = 1'b0;
        flush = 1'b0;
        issue_instr = '0;
        issue_valid = 1'b0;
        rs1_fwd = '0;
        rs2_fwd = '0;
        rs1_valid = 1'b0;
        rs2_valid = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rd_clobber[i] = NONE;
            shadow[i] = '0;
        end
        fu_ready = '{flu: 1'b1, lsu: 1'b1};
        commit = '0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        assert ((unit_valid == V_NONE) && (fu_data.fu == NONE) && (fu_data.op == ADD)) else begin
            mismatch_count++;
            $display("Mismatch at %0t: outputs not cleared by reset", $time);
        end
        rst_ni = 1'b1;

        // register writes through both commit ports and read back
        for (int i = 0; i < 8; i++) begin
            rand_bits(5, r);
            ra = r[4:0];
            rand_bits(5, r);
            rb = r[4:0];
            rand_bits(32, r);
            rand_bits(32, d);
            commit_pair(ra, r, rb, d);
        end
        rand_bits(32, r);
        rand_bits(32, d);
        commit_pair(5'd7, r, 5'd7, d);
        commit_pair(5'd0, 32'hffff_ffff, 5'd12, 32'h1357_9bdf);
        issue_check(make_instr(ALU, ADD, 5'd7, 5'd12, 5'd1), 1'b1, V_ALU, 1'b1, d, shadow[12]);
        issue_check(make_instr(ALU, ADD, 5'd0, 5'd7, 5'd1), 1'b1, V_ALU, 1'b1, '0, d);
        for (int i = 0; i < 8; i++) begin
            rand_bits(5, r);
            ra = r[4:0];
            rand_bits(5, r);
            rb = r[4:0];
            issue_check(make_instr(ALU, XOR, ra, rb, 5'd1), 1'b1, V_ALU, 1'b1,
                        shadow[ra], shadow[rb]);
        end

        // forwarding and source stalls
        rd_clobber[5] = ALU;
        rs1_fwd = 32'hdead_beef;
        rs1_valid = 1'b1;
        issue_check(make_instr(ALU, ADD, 5'd5, 5'd2, 5'd1), 1'b1, V_ALU, 1'b1,
                    32'hdead_beef, shadow[2]);
        rs1_valid = 1'b0;
        issue_check(make_instr(ALU, ADD, 5'd5, 5'd2, 5'd1), 1'b0, V_NONE, 1'b0, '0, '0);
        rd_clobber[5] = CSR;
        rs1_valid = 1'b1;
        issue_check(make_instr(ALU, ADD, 5'd5, 5'd2, 5'd1), 1'b0, V_NONE, 1'b0, '0, '0);
        ins = make_instr(CSR, CSRRW, 5'd5, 5'd0, 5'd1);
        ins.use_zimm = 1'b1;
        issue_check(ins, 1'b1, V_CSR, 1'b1, 32'd5, '0);
        rd_clobber[5] = NONE;
        rd_clobber[6] = LOAD;
        rs2_fwd = 32'h1234_5678;
        rs2_valid = 1'b1;
        issue_check(make_instr(ALU, SUB, 5'd3, 5'd6, 5'd1), 1'b1, V_ALU, 1'b1,
                    shadow[3], 32'h1234_5678);
        rs2_valid = 1'b0;
        issue_check(make_instr(ALU, SUB, 5'd3, 5'd6, 5'd1), 1'b0, V_NONE, 1'b0, '0, '0);
        rd_clobber[6] = NONE;
        rs1_valid = 1'b0;

        // operand selection from pc and immediate
        ins = make_instr(CTRL_FLOW, JAL, 5'd4, 5'd8, 5'd1);
        ins.use_pc = 1'b1;
        issue_check(ins, 1'b1, V_BR, 1'b1, ins.pc, shadow[8]);
        ins = make_instr(ALU, ADD, 5'd4, 5'd8, 5'd1);
        ins.use_imm = 1'b1;
        issue_check(ins, 1'b1, V_ALU, 1'b1, shadow[4], ins.result);
        ins = make_instr(STORE, SW, 5'd4, 5'd8, 5'd0);
        ins.use_imm = 1'b1;
        issue_check(ins, 1'b1, V_LSU, 1'b1, shadow[4], shadow[8]);
        ins = make_instr(CTRL_FLOW, BEQ, 5'd4, 5'd8, 5'd0);
        ins.use_imm = 1'b1;
        issue_check(ins, 1'b1, V_BR, 1'b1, shadow[4], shadow[8]);

        // each unit gets its own pulse
        issue_check(make_instr(CSR, CSRRS, 5'd3, 5'd4, 5'd1), 1'b1, V_CSR, 1'b1,
                    shadow[3], shadow[4]);
        issue_check(make_instr(LOAD, LW, 5'd3, 5'd4, 5'd1), 1'b1, V_LSU, 1'b1,
                    shadow[3], shadow[4]);
        issue_check(make_instr(MULT, MUL, 5'd3, 5'd4, 5'd1), 1'b1, V_MUL, 1'b1,
                    shadow[3], shadow[4]);
        @(negedge clk_i);

        // busy units hold the ack while exceptions and NONE drain anyway
        fu_ready = '{flu: 1'b0, lsu: 1'b1};
        issue_check(make_instr(ALU, ADD, 5'd3, 5'd4, 5'd1), 1'b0, V_NONE, 1'b0, '0, '0);
        issue_check(make_instr(CSR, CSRRW, 5'd3, 5'd4, 5'd1), 1'b0, V_NONE, 1'b0, '0, '0);
        issue_check(make_instr(LOAD, LW, 5'd3, 5'd4, 5'd1), 1'b1, V_LSU, 1'b0, '0, '0);
        fu_ready = '{flu: 1'b1, lsu: 1'b0};
        issue_check(make_instr(STORE, SW, 5'd3, 5'd4, 5'd0), 1'b0, V_NONE, 1'b0, '0, '0);
        issue_check(make_instr(ALU, OR, 5'd3, 5'd4, 5'd1), 1'b1, V_ALU, 1'b0, '0, '0);
        fu_ready = '{flu: 1'b0, lsu: 1'b0};
        ins = make_instr(ALU, ADD, 5'd3, 5'd4, 5'd1);
        ins.ex_valid = 1'b1;
        issue_check(ins, 1'b1, V_NONE, 1'b0, '0, '0);
        issue_check(make_instr(NONE, ADD, 5'd3, 5'd4, 5'd1), 1'b1, V_NONE, 1'b0, '0, '0);
        fu_ready = '{flu: 1'b1, lsu: 1'b1};

        // write after write on rd, freed only by a commit to rd in the same cycle
        // the same-cycle commit to x1 is not yet visible to the read
        rd_clobber[9] = LOAD;
        issue_check(make_instr(ALU, ADD, 5'd1, 5'd2, 5'd9), 1'b0, V_NONE, 1'b0, '0, '0);
        commit[0] = '{waddr: 5'd1, wdata: 32'h0f0f_1111, we: 1'b1};
        commit[1] = '{waddr: 5'd9, wdata: 32'h0bad_f00d, we: 1'b1};
        issue_check(make_instr(ALU, ADD, 5'd1, 5'd2, 5'd9), 1'b1, V_ALU, 1'b1,
                    shadow[1], shadow[2]);
        commit = '0;
        shadow[1] = 32'h0f0f_1111;
        shadow[9] = 32'h0bad_f00d;
        rd_clobber[9] = NONE;
        issue_check(make_instr(ALU, AND, 5'd1, 5'd9, 5'd2), 1'b1, V_ALU, 1'b1,
                    32'h0f0f_1111, 32'h0bad_f00d);

        // flush kills the pulse before multiply ordering
        flush = 1'b1;
        issue_check(make_instr(ALU, ADD, 5'd3, 5'd4, 5'd1), 1'b1, V_NONE, 1'b0, '0, '0);
        flush = 1'b0;
        issue_check(make_instr(MULT, MUL, 5'd3, 5'd4, 5'd1), 1'b1, V_MUL, 1'b0, '0, '0);
        issue_check(make_instr(ALU, ADD, 5'd3, 5'd4, 5'd1), 1'b0, V_NONE, 1'b0, '0, '0);
        issue_check(make_instr(MULT, MUL, 5'd3, 5'd4, 5'd1), 1'b1, V_MUL, 1'b0, '0, '0);
        issue_check(make_instr(MULT, MULH, 5'd3, 5'd4, 5'd1), 1'b1, V_MUL, 1'b0, '0, '0);
        issue_check(make_instr(LOAD, LW, 5'd3, 5'd4, 5'd1), 1'b0, V_NONE, 1'b0, '0, '0);
        repeat (2) @(negedge clk_i);

        $display("checks done: %0d ack mismatches, %0d output mismatches",
                 ack_mismatch_count, mismatch_count);
        if ((mismatch_count == 0) && (ack_mismatch_count == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
